//--- verilog/db_pkg.sv
// Key-value table shared widths, opcode encoding and request and response structures
`default_nettype none

package db_pkg;

    // --------------------
    // Widths
    // --------------------

    // The key is used directly as the RAM address
    localparam int key_wid = 5;
    localparam int value_wid = 16;

    // One extra bit per entry holds the valid flag
    localparam int entry_wid = value_wid + 1;

    // Number of entries in the table
    localparam int num_keys = 1 << key_wid;

    // --------------------
    // Opcodes
    // --------------------

    typedef enum logic [1:0] {
        op_get   = 2'd0,
        op_set   = 2'd1,
        op_del   = 2'd2,
        op_clear = 2'd3
    } db_op_e;

    // --------------------
    // Structures
    // --------------------

    // Command as presented on the command port
    typedef struct packed {
        db_op_e                 op;
        logic [key_wid-1:0]     key;
        logic [value_wid-1:0]   value;
    } db_cmd_t;

    // Write request toward the store array, valid low means a Delete
    typedef struct packed {
        logic [key_wid-1:0]     key;
        logic                   valid;
        logic [value_wid-1:0]   value;
    } db_wr_t;

    // Read request toward the store array
    typedef struct packed {
        logic [key_wid-1:0]     key;
    } db_rd_t;

    // Word as stored in the RAM
    typedef struct packed {
        logic                   valid;
        logic [value_wid-1:0]   value;
    } db_entry_t;

    // Result of a Get as presented on the result port
    typedef struct packed {
        logic [key_wid-1:0]     key;
        logic                   hit;
        logic [value_wid-1:0]   value;
    } db_result_t;

endpackage : db_pkg

`default_nettype wire

//--- verilog/db_ram_sdp.sv
// Simple dual port RAM with a registered read port and a reset sweep that zeroes every word
`timescale 1ns/1ps
`default_nettype none

module db_ram_sdp import db_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   clear,
    input  wire logic                   wr_en,
    input  wire logic [key_wid-1:0]     wr_addr,
    input  wire logic [entry_wid-1:0]   wr_data,
    input  wire logic                   rd_en,
    input  wire logic [key_wid-1:0]     rd_addr,
    output logic [entry_wid-1:0]        rd_data,
    output logic                        rd_ack,
    output logic                        init_done
);

    // --------------------
    // Storage
    // --------------------

    logic [entry_wid-1:0] mem [0:num_keys-1];

    // --------------------
    // Sweep FSM
    // --------------------

    typedef enum logic {
        st_idle,
        st_clear
    } ram_state_e;

    ram_state_e          state;
    logic [key_wid-1:0]  clr_addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            // A sweep always follows reset
            state     <= st_clear;
            clr_addr  <= '0;
            init_done <= 1'b0;
        end else begin
            unique case (state)
                st_idle: begin
                    if (clear) begin
                        state     <= st_clear;
                        clr_addr  <= '0;
                        init_done <= 1'b0;
                    end
                end
                st_clear: begin
                    if (clear) begin
                        // A new clear request restarts the sweep from the bottom
                        clr_addr <= '0;
                    end else if (clr_addr == key_wid'(num_keys - 1)) begin
                        // Last address is written on this edge
                        state     <= st_idle;
                        init_done <= 1'b1;
                    end else begin
                        clr_addr <= clr_addr + 1'b1;
                    end
                end
            endcase
        end
    end

    // --------------------
    // Write port
    // --------------------

    // The sweep owns the write port while it runs
    always_ff @(posedge clk) begin
        if (state == st_clear) begin
            mem[clr_addr] <= '0;
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // --------------------
    // Read port
    // --------------------

    // One cycle read latency, old data is returned on a same address collision
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ack <= 1'b0;
        end else begin
            rd_ack <= rd_en;
        end
    end

endmodule : db_ram_sdp

`default_nettype wire

//--- verilog/db_store_array.sv
// Store array that maps keys onto RAM addresses and packs the valid bit with each value
`timescale 1ns/1ps
`default_nettype none

module db_store_array import db_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       init,
    input  wire logic       wr_req,
    input  wire db_wr_t     wr,
    input  wire logic       rd_req,
    input  wire db_rd_t     rd,
    output logic            init_done,
    output logic            rd_ack,
    output db_entry_t       rd_entry
);

    // --------------------
    // RAM side signals
    // --------------------

    logic                   wr_en;
    logic                   rd_en;
    logic [key_wid-1:0]     wr_addr;
    logic [key_wid-1:0]     rd_addr;
    db_entry_t              wr_word;
    logic [entry_wid-1:0]   rd_word;

    // Requests are held off while a sweep runs, so the sweep wins over a late write
    assign wr_en = wr_req & init_done;
    assign rd_en = rd_req & init_done;

    // Keys address the RAM directly, there is no hashing
    assign wr_addr = wr.key;
    assign rd_addr = rd.key;

    // Entry packing, valid bit on top of the value
    assign wr_word.valid = wr.valid;
    assign wr_word.value = wr.value;
    assign rd_entry      = db_entry_t'(rd_word);

    // --------------------
    // Entry memory
    // --------------------

    db_ram_sdp u_ram (
        .clk       (clk),
        .reset     (reset),
        .clear     (init),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_word),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_word),
        .rd_ack    (rd_ack),
        .init_done (init_done)
    );

endmodule : db_store_array

`default_nettype wire

//--- verilog/db_cmd_decoder.sv
// Command decoder that accepts table commands and turns them into write, read and clear requests
`timescale 1ns/1ps
`default_nettype none

module db_cmd_decoder import db_pkg::*; (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               cmd_valid,
    input  wire db_cmd_t            cmd,
    input  wire logic               init_done,
    output logic                    cmd_ready,
    output logic                    wr_req,
    output db_wr_t                  wr,
    output logic                    rd_req,
    output db_rd_t                  rd,
    output logic                    init,
    output logic                    get_issue,
    output logic [key_wid-1:0]      get_key
);

    // --------------------
    // State
    // --------------------

    typedef enum logic {
        st_sweep,
        st_run
    } dec_state_e;

    dec_state_e state;
    logic       accept;

    // Commands are only taken while no sweep is running
    assign cmd_ready = (state == st_run);
    assign accept    = cmd_valid & cmd_ready;

    // --------------------
    // Control
    // --------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_sweep;
            wr_req    <= 1'b0;
            rd_req    <= 1'b0;
            init      <= 1'b0;
            get_issue <= 1'b0;
        end else begin
            // All request strobes are single cycle pulses
            wr_req    <= accept && (cmd.op == op_set || cmd.op == op_del);
            rd_req    <= accept && (cmd.op == op_get);
            get_issue <= accept && (cmd.op == op_get);
            init      <= accept && (cmd.op == op_clear);

            unique case (state)
                st_sweep: begin
                    // While the init pulse is out, init_done has not dropped yet,
                    // so it must not be taken as the end of the new sweep
                    if (init_done && !init) begin
                        state <= st_run;
                    end
                end
                st_run: begin
                    if (accept && cmd.op == op_clear) begin
                        state <= st_sweep;
                    end
                end
            endcase
        end
    end

    // --------------------
    // Payload
    // --------------------

    always_ff @(posedge clk) begin
        if (accept) begin
            // A Delete is a write that leaves the valid bit low
            wr.key    <= cmd.key;
            wr.valid  <= (cmd.op == op_set);
            wr.value  <= (cmd.op == op_set) ? cmd.value : '0;
            rd.key    <= cmd.key;
            get_key   <= cmd.key;
        end
    end

endmodule : db_cmd_decoder

`default_nettype wire

//--- verilog/db_result_formatter.sv
// Result formatter that pairs read data with the key of each pending Get and registers the result
`timescale 1ns/1ps
`default_nettype none

module db_result_formatter import db_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   get_issue,
    input  wire logic [key_wid-1:0]     get_key,
    input  wire logic                   rd_ack,
    input  wire db_entry_t              rd_entry,
    output logic                        result_valid,
    output db_result_t                  result
);

    // --------------------
    // Key alignment stage
    // --------------------

    // The RAM answers one cycle after the Get is issued, so the key waits one stage
    logic [key_wid-1:0] key_q;
    logic               pend_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            pend_q <= 1'b0;
        end else begin
            pend_q <= get_issue;
        end
    end

    always_ff @(posedge clk) begin
        if (get_issue) begin
            key_q <= get_key;
        end
    end

    // --------------------
    // Result register
    // --------------------

    // Only read data that belongs to a pending Get becomes a result
    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= rd_ack & pend_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_ack) begin
            result.key   <= key_q;
            result.hit   <= rd_entry.valid;
            // A miss never shows stale data
            result.value <= rd_entry.valid ? rd_entry.value : '0;
        end
    end

endmodule : db_result_formatter

`default_nettype wire

//--- verilog/db_table_top.sv
// Key-value lookup table top level joining the command decoder, store array and result formatter
`timescale 1ns/1ps
`default_nettype none

module db_table_top import db_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       cmd_valid,
    input  wire db_cmd_t    cmd,
    output logic            cmd_ready,
    output logic            result_valid,
    output db_result_t      result
);

    // --------------------
    // Internal nets
    // --------------------

    logic               wr_req;
    db_wr_t             wr;
    logic               rd_req;
    db_rd_t             rd;
    logic               init;
    logic               init_done;
    logic               get_issue;
    logic [key_wid-1:0] get_key;
    logic               rd_ack;
    db_entry_t          rd_entry;

    // Input side
    db_cmd_decoder u_decoder (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .init_done (init_done),
        .cmd_ready (cmd_ready),
        .wr_req    (wr_req),
        .wr        (wr),
        .rd_req    (rd_req),
        .rd        (rd),
        .init      (init),
        .get_issue (get_issue),
        .get_key   (get_key)
    );

    // Entry storage
    db_store_array u_store (
        .clk       (clk),
        .reset     (reset),
        .init      (init),
        .wr_req    (wr_req),
        .wr        (wr),
        .rd_req    (rd_req),
        .rd        (rd),
        .init_done (init_done),
        .rd_ack    (rd_ack),
        .rd_entry  (rd_entry)
    );

    // Output side
    db_result_formatter u_formatter (
        .clk          (clk),
        .reset        (reset),
        .get_issue    (get_issue),
        .get_key      (get_key),
        .rd_ack       (rd_ack),
        .rd_entry     (rd_entry),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule : db_table_top

`default_nettype wire

//--- bench/db_table_checker.sv
// Protocol assertions for the key-value table, bound into the top level
`timescale 1ns/1ps
`default_nettype none

module db_table_checker import db_pkg::*; (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           cmd_valid,
    input  wire db_cmd_t        cmd,
    input  wire logic           cmd_ready,
    input  wire logic           result_valid,
    input  wire db_result_t     result
);

    // A Get taken on this edge
    logic get_acc;

    assign get_acc = cmd_valid && cmd_ready && (cmd.op == op_get);

    // --------------------
    // Properties
    // --------------------

    // The result register loads two edges after the accepting edge,
    // so it is seen three samples later
    result_has_get: assert property (@(posedge clk) disable iff (reset)
        result_valid |-> $past(get_acc, 3))
        else $error("result_valid high without a Get accepted two edges earlier");

    get_has_result: assert property (@(posedge clk) disable iff (reset)
        get_acc |-> ##3 result_valid)
        else $error("accepted Get produced no result two edges later");

    // No command may be taken while reset is applied
    ready_low_in_reset: assert property (@(posedge clk)
        reset |=> !cmd_ready)
        else $error("cmd_ready high during reset");

    // Each result carries the key of the Get that produced it
    result_key_matches: assert property (@(posedge clk) disable iff (reset)
        result_valid |-> (result.key == $past(cmd.key, 3)))
        else $error("result key differs from the key of its Get");

endmodule : db_table_checker

bind db_table_top db_table_checker chk0 (
    .clk          (clk),
    .reset        (reset),
    .cmd_valid    (cmd_valid),
    .cmd          (cmd),
    .cmd_ready    (cmd_ready),
    .result_valid (result_valid),
    .result       (result)
);

`default_nettype wire

//--- bench/db_table_tb.sv
// Testbench for the key-value lookup table with a directed table and a random run
`timescale 1ns/1ps
`default_nettype none

module db_table_tb import db_pkg::*; ();

    localparam int clk_period   = 100;
    localparam int rand_cmds    = 200;
    localparam int sweep_cycles = 40;

    // One row of the directed table, expected values only matter for a Get
    typedef struct packed {
        db_cmd_t                cmd;
        logic                   exp_hit;
        logic [value_wid-1:0]   exp_value;
    } row_t;

    // A Get waiting for its result, with the cycle it must show up in
    typedef struct packed {
        db_result_t             res;
        int unsigned            due;
    } pend_t;

    logic           clk = 1'b0;
    logic           reset;
    logic           cmd_valid;
    db_cmd_t        cmd;
    logic           cmd_ready;
    logic           result_valid;
    db_result_t     result;

    row_t                   rows [$];
    pend_t                  pend_q [$];
    logic                   ref_valid [num_keys];
    logic [value_wid-1:0]   ref_value [num_keys];
    int unsigned            cyc = 0;
    int                     errors = 0;
    int                     checked = 0;
    bit                     table_ready = 1'b0;

    db_table_top dut0 (
        .clk          (clk),
        .reset        (reset),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .cmd_ready    (cmd_ready),
        .result_valid (result_valid),
        .result       (result)
    );

    // --------------------
    // Clock and cycle count
    // --------------------

    always #(clk_period / 2) clk = ~clk;

    // Rising edges seen so far, read on the falling edge
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // --------------------
    // Helpers
    // --------------------

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic add_row(input db_op_e op, input logic [key_wid-1:0] key,
                           input logic [value_wid-1:0] value, input logic exp_hit,
                           input logic [value_wid-1:0] exp_value);
        row_t r;
        r.cmd.op    = op;
        r.cmd.key   = key;
        r.cmd.value = value;
        r.exp_hit   = exp_hit;
        r.exp_value = exp_value;
        rows.push_back(r);
    endtask

    // Reference model of the table, updated in command order
    task automatic update_model(input db_cmd_t c);
        case (c.op)
            op_set: begin
                ref_valid[c.key] = 1'b1;
                ref_value[c.key] = c.value;
            end
            op_del: begin
                ref_valid[c.key] = 1'b0;
            end
            op_clear: begin
                for (int k = 0; k < num_keys; k++) begin
                    ref_valid[k] = 1'b0;
                end
            end
            default: ;
        endcase
    endtask

    // Called on a falling edge, waits for cmd_ready and presents one command
    task automatic apply_cmd(input db_cmd_t c, input logic exp_hit,
                             input logic [value_wid-1:0] exp_value);
        pend_t p;
        while (cmd_ready !== 1'b1) begin
            cmd_valid = 1'b0;
            @(negedge clk);
        end
        cmd_valid = 1'b1;
        cmd       = c;
        if (c.op == op_get) begin
            // Accepted on the next rising edge, result registered two edges later
            p.res.key   = c.key;
            p.res.hit   = exp_hit;
            p.res.value = exp_value;
            p.due       = cyc + 3;
            pend_q.push_back(p);
        end
        update_model(c);
        @(negedge clk);
    endtask

    // --------------------
    // Result monitor
    // --------------------

    always @(negedge clk) begin : result_monitor
        pend_t p;
        if (reset === 1'b0) begin
            // Anything overdue never came out
            while (pend_q.size() > 0 && pend_q[0].due < cyc) begin
                p = pend_q.pop_front();
                errors++;
                $display("No result for the Get of key %0d, due in cycle %0d, at %0t",
                         p.res.key, p.due, $time);
            end
            if (result_valid === 1'b1) begin
                if (pend_q.size() == 0) begin
                    errors++;
                    $display("Result for key %0d at %0t with no Get pending",
                             result.key, $time);
                end else begin
                    p = pend_q.pop_front();
                    checked++;
                    check_value("result cycle", p.due, cyc);
                    check_value("result.key", p.res.key, result.key);
                    check_value("result.hit", p.res.hit, result.hit);
                    check_value("result.value", p.res.value, result.value);
                end
            end
        end
    end

    // --------------------
    // Watchdog
    // --------------------

    initial begin : watchdog
        int unsigned limit_cycles;
        wait (table_ready);
        limit_cycles = (rows.size() + rand_cmds + 3 * sweep_cycles) * 2;
        #(limit_cycles * clk_period);
        $display("Timeout after %0t, the command sequence did not finish", $time);
        $display("ERRORS FOUND");
        $finish;
    end

    // --------------------
    // Stimulus
    // --------------------

    initial begin : stimulus
        int unsigned seed_dummy;
        db_cmd_t     c;
        logic        hit;

        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        seed_dummy = $urandom(84244);

        // Nothing written yet, every key misses
        add_row(op_get, 5'd0, 16'h0, 1'b0, 16'h0);
        add_row(op_get, 5'd7, 16'h0, 1'b0, 16'h0);
        add_row(op_get, 5'd31, 16'h0, 1'b0, 16'h0);
        // A Get right behind a Set sees the new value
        add_row(op_set, 5'd3, 16'h1234, 1'b0, 16'h0);
        add_row(op_get, 5'd3, 16'h0, 1'b1, 16'h1234);
        // Key 4 is deleted, its neighbors keep their values
        add_row(op_set, 5'd4, 16'hbeef, 1'b0, 16'h0);
        add_row(op_set, 5'd5, 16'h0a0a, 1'b0, 16'h0);
        add_row(op_del, 5'd4, 16'h0, 1'b0, 16'h0);
        add_row(op_get, 5'd4, 16'h0, 1'b0, 16'h0);
        add_row(op_get, 5'd3, 16'h0, 1'b1, 16'h1234);
        add_row(op_get, 5'd5, 16'h0, 1'b1, 16'h0a0a);
        // Clear wipes everything written above
        add_row(op_clear, 5'd0, 16'h0, 1'b0, 16'h0);
        add_row(op_get, 5'd3, 16'h0, 1'b0, 16'h0);
        add_row(op_get, 5'd5, 16'h0, 1'b0, 16'h0);
        // Back to back Gets come out in order, one per cycle
        add_row(op_set, 5'd10, 16'h1111, 1'b0, 16'h0);
        add_row(op_set, 5'd11, 16'h2222, 1'b0, 16'h0);
        add_row(op_set, 5'd12, 16'h3333, 1'b0, 16'h0);
        add_row(op_get, 5'd10, 16'h0, 1'b1, 16'h1111);
        add_row(op_get, 5'd11, 16'h0, 1'b1, 16'h2222);
        add_row(op_get, 5'd12, 16'h0, 1'b1, 16'h3333);
        add_row(op_get, 5'd13, 16'h0, 1'b0, 16'h0);
        table_ready = 1'b1;

        for (int k = 0; k < num_keys; k++) begin
            ref_valid[k] = 1'b0;
            ref_value[k] = '0;
        end

        repeat (4) @(negedge clk);
        reset = 1'b0;

        foreach (rows[i]) begin
            apply_cmd(rows[i].cmd, rows[i].exp_hit, rows[i].exp_value);
            if (rows[i].cmd.op == op_clear && cmd_ready !== 1'b0) begin
                errors++;
                $display("cmd_ready stayed high after a Clear was accepted at %0t", $time);
            end
        end

        // Random Set, Delete and Get over the lower half of the keys
        for (int n = 0; n < rand_cmds; n++) begin
            case ($urandom_range(2, 0))
                0: c.op = op_get;
                1: c.op = op_set;
                default: c.op = op_del;
            endcase
            c.key   = key_wid'($urandom_range(15, 0));
            c.value = value_wid'($urandom);
            hit     = ref_valid[c.key];
            apply_cmd(c, hit, hit ? ref_value[c.key] : '0);
        end
        cmd_valid = 1'b0;

        // The last Get is due three falling edges after it was driven
        repeat (4) @(negedge clk);
        if (pend_q.size() != 0) begin
            errors++;
            $display("%0d Get results never arrived", pend_q.size());
        end

        $display("Run finished with %0d errors over %0d results", errors, checked);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule : db_table_tb

`default_nettype wire

//--- files.f
verilog/db_pkg.sv
verilog/db_ram_sdp.sv
verilog/db_store_array.sv
verilog/db_cmd_decoder.sv
verilog/db_result_formatter.sv
verilog/db_table_top.sv
bench/db_table_checker.sv
bench/db_table_tb.sv
